// ==== hdl/cgra_net_pkg.sv ====
package cgra_net_pkg;

  // configuration types carried in bits 7:0 of every bus word
  localparam logic [7:0] conf_none            = 8'd0;
  localparam logic [7:0] conf_pe_instruction  = 8'd1;
  localparam logic [7:0] conf_pe_const        = 8'd2;
  localparam logic [7:0] conf_pe_pc_max       = 8'd3;
  localparam logic [7:0] conf_pe_pc_loop      = 8'd4;
  localparam logic [7:0] conf_pe_store_ignore = 8'd5;
  localparam logic [7:0] conf_net_pc_max      = 8'd6;
  localparam logic [7:0] conf_net_pc_loop     = 8'd7;
  localparam logic [7:0] conf_net_switch      = 8'd8;

  localparam int conf_w    = 64;
  localparam int lane_w    = 8;
  localparam int num_lanes = 4;
  localparam int sel_w     = 2;  // source select per output lane
  localparam int pc_w      = 8;

  // routing memory write
  typedef struct packed {
    logic [7:0]  unused;
    logic [15:0] route;      // low byte used
    logic [15:0] addr;       // low byte used
    logic [15:0] switch_id;
    logic [7:0]  conf_type;
  } conf_net_t;

  // loop bound write
  typedef struct packed {
    logic [7:0]  unused;
    logic [31:0] value;      // low byte used
    logic [15:0] switch_id;
    logic [7:0]  conf_type;
  } conf_pc_t;

  typedef union packed {
    conf_net_t net;
    conf_pc_t  pc;
  } conf_word_u;

endpackage

// ==== hdl/conf_axil_bridge.sv ====
`timescale 1ns/1ps

module conf_axil_bridge
  import cgra_net_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              awvalid,
  output logic              awready,
  input  logic [3:0]        awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  output logic              bvalid,
  input  logic              bready,
  output logic [1:0]        bresp,
  input  logic              arvalid,
  output logic              arready,
  input  logic [3:0]        araddr,
  output logic              rvalid,
  input  logic              rready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic [conf_w-1:0] conf_bus
);

  logic [31:0] conf_lo;
  logic [31:0] conf_hi;
  logic [31:0] lo_merged;
  logic [31:0] hi_merged;
  logic        wr_fire;
  logic        rd_fire;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
    logic [31:0] word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b])
        word[8*b +: 8] = data[8*b +: 8];
    end
    return word;
  endfunction

  assign wr_fire   = awvalid && awready && wvalid && wready;
  assign rd_fire   = arvalid && arready;
  assign lo_merged = merge_bytes(conf_lo, wdata, wstrb);
  assign hi_merged = merge_bytes(conf_hi, wdata, wstrb);
  assign bresp     = 2'b00;  // always OKAY
  assign rresp     = 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      conf_lo  <= '0;
      conf_hi  <= '0;
      conf_bus <= '0;
    end else begin
      // one-cycle ready, only while no response is pending
      awready  <= awvalid && wvalid && !bvalid && !awready;
      wready   <= awvalid && wvalid && !bvalid && !awready;
      conf_bus <= '0;
      if (wr_fire) begin
        bvalid <= 1'b1;
        if (awaddr == 4'h0)
          conf_lo <= lo_merged;
        if (awaddr == 4'h4) begin
          conf_hi  <= hi_merged;
          conf_bus <= {hi_merged, conf_lo};  // launch the word
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !rvalid && !arready;
      if (rd_fire)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (araddr)
        4'h0:    rdata <= conf_lo;
        4'h4:    rdata <= conf_hi;
        default: rdata <= '0;  // unmapped
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid);

  // the bus only ever carries single-cycle words
  assert property (@(posedge clk) disable iff (rst) conf_bus != '0 |=> conf_bus == '0);

endmodule

// ==== hdl/switch_conf_reader.sv ====
`timescale 1ns/1ps

module switch_conf_reader
  import cgra_net_pkg::*;
#(
  parameter int switch_id = 0
)(
  input  logic              clk,
  input  logic              rst,
  input  logic [conf_w-1:0] conf_bus,
  output logic [pc_w-1:0]   pc_max,
  output logic [pc_w-1:0]   pc_loop,
  output logic              mem_we,
  output logic [pc_w-1:0]   mem_waddr,
  output logic [lane_w-1:0] mem_wdata
);

  conf_word_u        conf_q;
  logic              id_hit;
  logic              sw_hit;
  logic              bus_hit;
  logic              we_p;
  logic [pc_w-1:0]   waddr_p;
  logic [lane_w-1:0] wdata_p;

  always_ff @(posedge clk) begin
    if (rst)
      conf_q <= '0;
    else
      conf_q <= conf_bus;
  end

  assign id_hit = conf_q.net.switch_id == 16'(switch_id);
  assign sw_hit = id_hit && conf_q.net.conf_type == conf_net_switch;

  // raw bus fields of a routing write for this switch
  assign bus_hit = conf_bus[7:0] == conf_net_switch && conf_bus[23:8] == 16'(switch_id);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_max  <= '0;
      pc_loop <= '0;
      we_p    <= 1'b0;
      mem_we  <= 1'b0;
    end else begin
      we_p   <= sw_hit;
      mem_we <= we_p;
      if (id_hit) begin
        case (conf_q.pc.conf_type)
          conf_net_pc_max:  pc_max  <= conf_q.pc.value[pc_w-1:0];
          conf_net_pc_loop: pc_loop <= conf_q.pc.value[pc_w-1:0];
          conf_none, conf_pe_instruction, conf_pe_const, conf_pe_pc_max,
          conf_pe_pc_loop, conf_pe_store_ignore: ;  // no PEs in this stage
          default: ;  // net_switch goes through the write pipe
        endcase
      end
    end
  end

  // two-stage write pipe so back-to-back words can overlap
  always_ff @(posedge clk) begin
    waddr_p   <= conf_q.net.addr[pc_w-1:0];
    wdata_p   <= conf_q.net.route[lane_w-1:0];
    mem_waddr <= waddr_p;
    mem_wdata <= wdata_p;
  end

  // every memory write traces back to a matching word three cycles earlier
  assert property (@(posedge clk) disable iff (rst)
    mem_we |-> $past(bus_hit, 3));

endmodule

// ==== hdl/switch_conf_mem.sv ====
`timescale 1ns/1ps

module switch_conf_mem
  import cgra_net_pkg::*;
(
  input  logic              clk,
  input  logic              we,
  input  logic [pc_w-1:0]   waddr,
  input  logic [lane_w-1:0] wdata,
  input  logic [pc_w-1:0]   raddr,
  output logic [lane_w-1:0] rdata
);

  logic [lane_w-1:0] mem [2**pc_w];

  initial begin
    for (int i = 0; i < 2**pc_w; i++)
      mem[i] = '0;
  end

  always_ff @(posedge clk) begin
    if (we)
      mem[waddr] <= wdata;
    rdata <= mem[raddr];  // route for the crossbar's next cycle
  end

endmodule

// ==== hdl/switch_pc.sv ====
`timescale 1ns/1ps

module switch_pc
  import cgra_net_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            run,
  input  logic [pc_w-1:0] pc_max,
  input  logic [pc_w-1:0] pc_loop,
  output logic [pc_w-1:0] pc
);

  always_ff @(posedge clk) begin
    if (rst || !run)
      pc <= '0;
    else if (pc == pc_max)
      pc <= pc_loop;  // wrap back into the loop body
    else
      pc <= pc + 1'b1;
  end

  // program restarts from step 0 whenever run drops
  assert property (@(posedge clk) disable iff (rst) !run |=> pc == '0);

endmodule

// ==== hdl/net_crossbar.sv ====
`timescale 1ns/1ps

module net_crossbar
  import cgra_net_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [lane_w-1:0]           route,
  input  logic [num_lanes*lane_w-1:0] lane_in,
  output logic [num_lanes*lane_w-1:0] lane_out
);

  logic [num_lanes*lane_w-1:0] lane_q;
  logic [num_lanes*lane_w-1:0] xbar_d;

  // lanes are sampled alongside the memory read
  always_ff @(posedge clk) begin
    lane_q <= lane_in;
  end

  always_comb begin
    for (int k = 0; k < num_lanes; k++)
      xbar_d[k*lane_w +: lane_w] = lane_q[route[sel_w*k +: sel_w]*lane_w +: lane_w];
  end

  always_ff @(posedge clk) begin
    if (rst)
      lane_out <= '0;
    else
      lane_out <= xbar_d;
  end

endmodule

// ==== hdl/cgra_net_top.sv ====
`timescale 1ns/1ps

module cgra_net_top
  import cgra_net_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        run,
  input  logic [num_lanes*lane_w-1:0] lane_in,
  output logic [num_lanes*lane_w-1:0] lane_out,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [3:0]                  awaddr,
  input  logic                        wvalid,
  output logic                        wready,
  input  logic [31:0]                 wdata,
  input  logic [3:0]                  wstrb,
  output logic                        bvalid,
  input  logic                        bready,
  output logic [1:0]                  bresp,
  input  logic                        arvalid,
  output logic                        arready,
  input  logic [3:0]                  araddr,
  output logic                        rvalid,
  input  logic                        rready,
  output logic [31:0]                 rdata,
  output logic [1:0]                  rresp
);

  logic [conf_w-1:0]           conf_bus;
  logic [pc_w-1:0]             pc_max_0, pc_loop_0, pc_0, waddr_0;
  logic [pc_w-1:0]             pc_max_1, pc_loop_1, pc_1, waddr_1;
  logic                        we_0, we_1;
  logic [lane_w-1:0]           wdata_0, route_0;
  logic [lane_w-1:0]           wdata_1, route_1;
  logic [num_lanes*lane_w-1:0] lane_mid;  // switch 0 to switch 1

  conf_axil_bridge i_conf_axil_bridge (
    .clk, .rst, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .rvalid, .rready,
    .rdata, .rresp, .conf_bus
  );

  // switch 0
  switch_conf_reader #(.switch_id(0)) i_reader_0 (
    .clk, .rst, .conf_bus, .pc_max(pc_max_0), .pc_loop(pc_loop_0),
    .mem_we(we_0), .mem_waddr(waddr_0), .mem_wdata(wdata_0)
  );
  switch_conf_mem i_mem_0 (
    .clk, .we(we_0), .waddr(waddr_0), .wdata(wdata_0), .raddr(pc_0), .rdata(route_0)
  );
  switch_pc i_pc_0 (.clk, .rst, .run, .pc_max(pc_max_0), .pc_loop(pc_loop_0), .pc(pc_0));
  net_crossbar i_xbar_0 (.clk, .rst, .route(route_0), .lane_in, .lane_out(lane_mid));

  // switch 1
  switch_conf_reader #(.switch_id(1)) i_reader_1 (
    .clk, .rst, .conf_bus, .pc_max(pc_max_1), .pc_loop(pc_loop_1),
    .mem_we(we_1), .mem_waddr(waddr_1), .mem_wdata(wdata_1)
  );
  switch_conf_mem i_mem_1 (
    .clk, .we(we_1), .waddr(waddr_1), .wdata(wdata_1), .raddr(pc_1), .rdata(route_1)
  );
  switch_pc i_pc_1 (.clk, .rst, .run, .pc_max(pc_max_1), .pc_loop(pc_loop_1), .pc(pc_1));
  net_crossbar i_xbar_1 (.clk, .rst, .route(route_1), .lane_in(lane_mid), .lane_out);

endmodule

// ==== verification/tb_cgra_net_top.sv ====
`timescale 1ns/1ps

module tb_cgra_net_top
  import cgra_net_pkg::*;
();

  localparam int run_cycles     = 300;
  localparam int timeout_cycles = 20 * run_cycles;  // far above the six tests together

  logic        clk, rst, run;
  logic [31:0] lane_in, lane_out;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [3:0]  awaddr, araddr, wstrb;
  logic [31:0] wdata, rdata;
  logic [1:0]  bresp, rresp;

  logic [31:0] rng;
  logic [7:0]  route_m [2][256];  // routing memory of each switch
  logic [7:0]  pc_max_m [2];
  logic [7:0]  pc_loop_m [2];
  logic [7:0]  pc_m [2];
  logic        run_m;             // run during the previous cycle
  logic [31:0] lo_m, hi_m;
  logic [31:0] hist_in [8];
  logic [7:0]  hist_pc0 [8];
  logic [7:0]  hist_pc1 [8];
  int          t, cycles, checks, errors, test_err;

  cgra_net_top i_cgra_net_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // output lane k takes the input lane named by route bits 2k+1:2k
  function automatic logic [31:0] route_lanes(input logic [7:0] route, input logic [31:0] lanes);
    logic [31:0] res;
    for (int k = 0; k < 4; k++)
      res[8*k +: 8] = lanes[8*route[2*k +: 2] +: 8];
    return res;
  endfunction

  // bytes whose strobe bit is set take the new data
  function automatic logic [31:0] strobe_merge(input logic [31:0] old_word,
                                               input logic [31:0] data,
                                               input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (data & mask);
  endfunction

  function automatic logic [7:0] step_pc(input logic [7:0] pc, input logic [7:0] pmax,
                                         input logic [7:0] ploop, input logic go);
    if (!go)
      return 8'd0;
    return (pc == pmax) ? ploop : pc + 8'd1;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      test_err++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d errors", name, test_err);
    errors += test_err;
    test_err = 0;
  endtask

  task automatic apply_word(input logic [63:0] w);
    if (w[23:9] == 15'd0) begin  // switch 0 or 1
      case (w[7:0])
        conf_net_pc_max:  pc_max_m[w[8]] = w[31:24];
        conf_net_pc_loop: pc_loop_m[w[8]] = w[31:24];
        conf_net_switch:  route_m[w[8]][w[31:24]] = w[47:40];
        default: ;
      endcase
    end
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int delay;
    delay = int'(next_rand() % 4);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    @(posedge clk);
    while (!(awready && wready))
      @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge clk);
    while (!bvalid)
      @(posedge clk);
    check_eq(32'(bresp), 32'd0, "bresp");
    repeat (delay) @(posedge clk);  // response held back by the host
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
    if (addr == 4'h0)
      lo_m = strobe_merge(lo_m, data, strb);
    if (addr == 4'h4) begin
      hi_m = strobe_merge(hi_m, data, strb);
      apply_word({hi_m, lo_m});
    end
  endtask

  task automatic read_reg(input logic [3:0] addr, input logic [31:0] exp);
    arvalid <= 1'b1;
    araddr  <= addr;
    @(posedge clk);
    while (!arready)
      @(posedge clk);
    arvalid <= 1'b0;
    @(posedge clk);
    while (!rvalid)
      @(posedge clk);
    check_eq(rdata, exp, $sformatf("read of offset %0h", addr));
    check_eq(32'(rresp), 32'd0, "rresp");
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic send_word(input logic [7:0] ctype, input logic [15:0] id,
                           input logic [7:0] a, input logic [7:0] r);
    logic [63:0] w;
    w = {16'h0000, r, 8'h00, a, id, ctype};  // a carries addr or value and r the route
    write_reg(4'h0, w[31:0], 4'hf);
    write_reg(4'h4, w[63:32], 4'hf);
  endtask

  // let pending memory writes land while pc sits at 0 with run low
  task automatic restart_model();
    repeat (6) @(posedge clk);
    t = 0;
    pc_m[1'b0] = 8'd0;
    pc_m[1'b1] = 8'd0;
    run_m = 1'b0;
  endtask

  task automatic drive_cycles(input int n, input logic run_level);
    logic [31:0] exp;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      // lane_out of cycle t-1 is switch 1 at t-3 applied to switch 0 at t-5
      if (t >= 5) begin
        exp = route_lanes(route_m[1'b1][hist_pc1[3'(t - 3)]],
                          route_lanes(route_m[1'b0][hist_pc0[3'(t - 5)]], hist_in[3'(t - 5)]));
        check_eq(lane_out, exp, $sformatf("lane_out, model cycle %0d", t - 1));
      end
      pc_m[1'b0] = step_pc(pc_m[1'b0], pc_max_m[1'b0], pc_loop_m[1'b0], run_m);
      pc_m[1'b1] = step_pc(pc_m[1'b1], pc_max_m[1'b1], pc_loop_m[1'b1], run_m);
      run_m = run_level;
      hist_in[3'(t)]  = next_rand();
      hist_pc0[3'(t)] = pc_m[1'b0];
      hist_pc1[3'(t)] = pc_m[1'b1];
      run     <= run_level;
      lane_in <= hist_in[3'(t)];
      t++;
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0] lo;
    logic [7:0]  pmax;
    logic [7:0]  ploop;
    rng = 32'h4a92_a772;
    rst = 1'b1;
    run = 1'b0;
    lane_in = '0;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    wstrb = 4'hf;
    lo_m = '0;
    hi_m = '0;
    checks = 0;
    errors = 0;
    test_err = 0;
    t = 0;
    run_m = 1'b0;
    pc_max_m = '{8'h00, 8'h00};
    pc_loop_m = '{8'h00, 8'h00};
    pc_m = '{8'h00, 8'h00};
    for (int i = 0; i < 256; i++) begin
      route_m[1'b0][8'(i)] = 8'h00;
      route_m[1'b1][8'(i)] = 8'h00;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 8; i++) begin
      write_reg(4'h0, next_rand(), (i < 4) ? 4'hf : 4'(next_rand()));
      write_reg(4'h4, next_rand(), (i < 4) ? 4'hf : 4'(next_rand()));
      read_reg(4'h0, lo_m);
      read_reg(4'h4, hi_m);
    end
    read_reg(4'h8, 32'h0);
    read_reg(4'hc, 32'h0);
    finish_test("test 1 register access");

    send_word(conf_net_switch, 16'd0, 8'd0, 8'(next_rand()));
    send_word(conf_net_switch, 16'd1, 8'd0, 8'(next_rand()));
    restart_model();
    drive_cycles(60, 1'b0);
    finish_test("test 2 idle routing");

    for (int s = 0; s < 2; s++) begin
      pmax  = 8'(next_rand() % 16);
      ploop = 8'(next_rand() % (32'(pmax) + 32'd1));
      send_word(conf_net_pc_max, 16'(s), pmax, 8'd0);
      send_word(conf_net_pc_loop, 16'(s), ploop, 8'd0);
      for (int a = 0; a <= int'(pmax); a++)
        send_word(conf_net_switch, 16'(s), 8'(a), 8'(next_rand()));
    end
    restart_model();
    drive_cycles(run_cycles, 1'b1);
    drive_cycles(8, 1'b0);
    finish_test("test 3 looping program");

    for (int i = 0; i < 6; i++) begin
      send_word(conf_net_switch, 16'd1, 8'(next_rand() % 16), 8'(next_rand()));
      send_word(8'(6 + next_rand() % 3), 16'(2 + next_rand() % 65534),
                8'(next_rand()), 8'(next_rand()));
    end
    restart_model();
    drive_cycles(100, 1'b1);
    drive_cycles(8, 1'b0);
    finish_test("test 4 switch addressing");

    for (int i = 0; i < 10; i++) begin
      lo = next_rand();
      lo[7:0]  = 8'(next_rand() % 6);  // none or a PE type
      lo[23:8] = 16'(next_rand() % 2);
      write_reg(4'h0, lo, 4'hf);
      write_reg(4'h4, next_rand(), 4'hf);
    end
    restart_model();
    drive_cycles(run_cycles, 1'b1);
    drive_cycles(8, 1'b0);
    finish_test("test 5 ignored types");

    restart_model();
    for (int i = 0; i < 4; i++) begin
      drive_cycles(20 + int'(next_rand() % 40), 1'b1);
      drive_cycles(1 + int'(next_rand() % 4), 1'b0);
    end
    drive_cycles(8, 1'b0);
    finish_test("test 6 run restart");

    $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/cgra_net_pkg.sv
hdl/conf_axil_bridge.sv
hdl/switch_conf_reader.sv
hdl/switch_conf_mem.sv
hdl/switch_pc.sv
hdl/net_crossbar.sv
hdl/cgra_net_top.sv
verification/tb_cgra_net_top.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_cgra_net_top -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "$out" | grep -q "^Result: PASSED$" || exit 1
exit 0
